//--- slide_unit.f
design/slide_pkg.sv
design/slide_result_if.sv
design/slide_insn_queue.sv
design/slide_issue.sv
design/slide_result_queue.sv
design/slide_unit.sv
testbench/tb_slide_unit.sv

//--- Makefile
# Verilator flow for the slide unit
VERILATOR  ?= verilator
TOP        ?= tb_slide_unit
RTL_TOP    ?= slide_unit
FILELIST   ?= slide_unit.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides: only a printed pass line counts as success
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_slide_unit.sv
`timescale 1ns/1ns

module tb_slide_unit;

  localparam int unsigned NrLanes        = 2;
  localparam int unsigned VLEN           = 512;
  localparam int unsigned InsnQueueDepth = 2;
  localparam int          WordBytes      = 8 * NrLanes;
  localparam int          RegBytes       = VLEN / 8;
  localparam int          MemBytes       = 32 * RegBytes;
  localparam int          Timeout        = 2000;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                pe_req_valid_i;
  slide_pkg::slide_op_e                pe_req_op_i;
  slide_pkg::vew_e                     pe_req_vsew_i;
  slide_pkg::vlen_t                    pe_req_vl_i;
  slide_pkg::vlen_t                    pe_req_stride_i;
  slide_pkg::vreg_t                    pe_req_vd_i;
  slide_pkg::vid_t                     pe_req_id_i;
  logic                                pe_req_ready_o;
  slide_pkg::elen_t  [NrLanes-1:0]     operand_i;
  logic              [NrLanes-1:0]     operand_valid_i;
  logic                                operand_ready_o;
  logic              [NrLanes-1:0]     result_req_o;
  slide_pkg::vaddr_t [NrLanes-1:0]     result_addr_o;
  slide_pkg::elen_t  [NrLanes-1:0]     result_wdata_o;
  slide_pkg::strb_t  [NrLanes-1:0]     result_be_o;
  logic              [NrLanes-1:0]     result_gnt_i;
  logic [slide_pkg::NrVInsn-1:0]       vinsn_done_o;

  // Per-id record of what was sent, read back by the reference
  slide_pkg::slide_op_e ins_op  [slide_pkg::NrVInsn];
  int                   ins_off [slide_pkg::NrVInsn];
  int                   ins_vlb [slide_pkg::NrVInsn];
  logic [7:0]           src_b   [slide_pkg::NrVInsn][2*RegBytes];
  // Lane register file model, byte granular
  logic [7:0]           mem_b   [MemBytes];
  logic                 wr_b    [MemBytes];

  logic [8*WordBytes-1:0] opq [$];
  int                     exp_ids [$];
  slide_pkg::vaddr_t      held_addr [NrLanes];
  slide_pkg::elen_t       held_data [NrLanes];
  slide_pkg::strb_t       held_be   [NrLanes];
  logic                   held_q    [NrLanes];

  logic [31:0] rng_q;
  logic        stall_en, hold_gnt, timed_out;
  int          next_id, errors, checks, dones;

  slide_unit #(
    .NrLanes       (NrLanes),
    .VLEN          (VLEN),
    .InsnQueueDepth(InsnQueueDepth)
  ) dut (.*);

  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] draw_rand();
    rng_q = xorshift32(rng_q);
    return rng_q;
  endfunction

  // Unwritten bytes keep this, spread over the whole address
  function automatic logic [7:0] poison(input int a);
    return 8'(a) ^ 8'(a >> 5) ^ 8'hc3;
  endfunction

  // Each id owns its own destination register, v8 to v15
  function automatic int dest_base(input int id);
    return (id + 8) * RegBytes;
  endfunction

  // Expected destination byte j, bit 8 tells whether it is written at all
  function automatic logic [8:0] slide_ref(input int id, input int j);
    int off;
    int vlb;
    off = ins_off[id];
    vlb = ins_vlb[id];
    if (ins_op[id] == slide_pkg::SLIDE_UP) begin
      if (j >= off && j < vlb) return {1'b1, src_b[id][j-off]};
    end else if (j < vlb) begin
      return {1'b1, src_b[id][j+off]};
    end
    return {1'b0, poison(dest_base(id) + j)};
  endfunction

  task automatic check_dest(input int id);
    int         base;
    logic [8:0] exp;
    base = dest_base(id);
    for (int j = 0; j < RegBytes; j++) begin
      exp    = slide_ref(id, j);
      checks = checks + 1;
      assert (wr_b[base+j] == exp[8]) else begin
        errors++;
        $display("Byte %0d of v%0d %s", j, id + 8,
                 exp[8] ? "was never written" : "was written outside the slide range");
      end
      assert (mem_b[base+j] == exp[7:0]) else begin
        errors++;
        $display("** Error: v%0d byte %0d = %h, expected %h", id + 8, j, mem_b[base+j],
                 exp[7:0]);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Lane side: operand stream and write grants
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : drive_lanes
    logic [31:0] r;
    for (int l = 0; l < NrLanes; l++) begin
      r = draw_rand();
      result_gnt_i[l] = result_req_o[l] && !hold_gnt && (!stall_en || r[1:0] != 2'd0);
    end
    if (opq.size() != 0) begin
      operand_i = opq[0];
      for (int l = 0; l < NrLanes; l++) begin
        r = draw_rand();
        operand_valid_i[l] = !stall_en || r[1:0] != 2'd0;
      end
    end else begin
      operand_valid_i = '0;
    end
  end

  // Handshakes are taken at the rising edge, where inputs settled since the falling one
  always @(posedge clk_i) begin : monitor
    int idx;
    int id;
    if (rst_ni) begin
      if (operand_ready_o && (&operand_valid_i)) begin
        assert (opq.size() != 0) else begin
          errors++;
          $display("Operand word taken while the lanes had none to give");
        end
        if (opq.size() != 0) void'(opq.pop_front());
      end

      for (int l = 0; l < NrLanes; l++) begin
        // A waiting request keeps its payload
        if (held_q[l]) begin
          checks = checks + 1;
          assert (result_req_o[l]) else begin
            errors++;
            $display("Lane %0d dropped its write request without a grant", l);
          end
          assert (result_addr_o[l] == held_addr[l]) else begin
            errors++;
            $display("** Error: result_addr_o[%0d] = %h, expected %h", l, result_addr_o[l],
                     held_addr[l]);
          end
          assert (result_wdata_o[l] == held_data[l]) else begin
            errors++;
            $display("** Error: result_wdata_o[%0d] = %h, expected %h", l, result_wdata_o[l],
                     held_data[l]);
          end
          assert (result_be_o[l] == held_be[l]) else begin
            errors++;
            $display("** Error: result_be_o[%0d] = %h, expected %h", l, result_be_o[l],
                     held_be[l]);
          end
        end
        held_q[l]    = result_req_o[l] && !result_gnt_i[l];
        held_addr[l] = result_addr_o[l];
        held_data[l] = result_wdata_o[l];
        held_be[l]   = result_be_o[l];

        // Granted write lands in the memory model
        if (result_req_o[l] && result_gnt_i[l]) begin
          for (int b = 0; b < 8; b++) begin
            idx = int'(result_addr_o[l]) * WordBytes + 8 * l + b;
            if (result_be_o[l][b] && idx < MemBytes) begin
              mem_b[idx] = result_wdata_o[l][8*b +: 8];
              wr_b[idx]  = 1'b1;
            end else if (result_be_o[l][b]) begin
              errors++;
              $display("Lane %0d wrote beyond the register file", l);
            end
          end
        end
      end

      // Done pulses come one at a time, in acceptance order
      if (vinsn_done_o != '0) begin
        dones++;
        assert (exp_ids.size() != 0) else begin
          errors++;
          $display("Done pulse with no instruction outstanding");
        end
        if (exp_ids.size() != 0) begin
          id     = exp_ids.pop_front();
          checks = checks + 1;
          assert (vinsn_done_o == (slide_pkg::NrVInsn'(1) << id)) else begin
            errors++;
            $display("** Error: vinsn_done_o = %h, expected %h", vinsn_done_o,
                     slide_pkg::NrVInsn'(1) << id);
          end
          check_dest(id);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer side
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_insn(input slide_pkg::slide_op_e op, input slide_pkg::vew_e vsew,
                           input int vl, input int stride);
    int                     id;
    int                     eb;
    int                     first;
    int                     nw;
    int                     cnt;
    logic [31:0]            r;
    logic [8*WordBytes-1:0] word;
    id          = next_id;
    next_id     = (next_id + 1) % slide_pkg::NrVInsn;
    eb          = 1 << int'(vsew);
    ins_op[id]  = op;
    ins_off[id] = stride * eb;
    ins_vlb[id] = vl * eb;
    for (int j = 0; j < 2 * RegBytes; j++) begin
      r            = draw_rand();
      src_b[id][j] = r[7:0];
    end
    for (int j = dest_base(id); j < dest_base(id) + RegBytes; j++) begin
      mem_b[j] = poison(j);
      wr_b[j]  = 1'b0;
    end
    // Slide-down starts at the word that holds the offset
    if (op == slide_pkg::SLIDE_UP) begin
      first = 0;
      nw    = (ins_vlb[id] - ins_off[id] + WordBytes - 1) / WordBytes;
    end else begin
      first = ins_off[id] / WordBytes;
      nw    = (ins_off[id] + ins_vlb[id] + WordBytes - 1) / WordBytes - first;
    end
    for (int w = first; w < first + nw; w++) begin
      for (int i = 0; i < WordBytes; i++) begin
        word[8*i +: 8] = src_b[id][WordBytes*w + i];
      end
      opq.push_back(word);
    end

    @(negedge clk_i);
    pe_req_valid_i  = 1'b1;
    pe_req_op_i     = op;
    pe_req_vsew_i   = vsew;
    pe_req_vl_i     = 16'(vl);
    pe_req_stride_i = 16'(stride);
    pe_req_vd_i     = 5'(id + 8);
    pe_req_id_i     = 3'(id);
    cnt             = 0;
    do begin
      @(posedge clk_i);
      cnt++;
    end while (!pe_req_ready_o && cnt < Timeout);
    if (pe_req_ready_o) begin
      exp_ids.push_back(id);
    end else begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: request for id %0d was never accepted", id);
    end
  endtask

  task automatic run_random(input slide_pkg::slide_op_e op, input slide_pkg::vew_e vsew);
    int          maxel;
    int          vl;
    logic [31:0] r;
    maxel = RegBytes >> int'(vsew);
    r     = draw_rand();
    vl    = 1 + int'(r % 32'(maxel));
    r     = draw_rand();
    send_insn(op, vsew, vl, int'(r % 32'(vl)));
  endtask

  task automatic end_reqs();
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_ids.size() != 0 && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (exp_ids.size() != 0) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: %0d instructions never signalled done", exp_ids.size());
    end
    assert (opq.size() == 0) else begin
      errors++;
      $display("%0d operand words were left unconsumed", opq.size());
    end
    opq.delete();
  endtask

  task automatic run_all();
    logic [31:0] r;
    int          cnt;

    // Idle outputs straight after reset
    checks = checks + 4;
    assert (result_req_o == '0) else begin
      errors++;
      $display("** Error: result_req_o = %h, expected %h", result_req_o, 2'h0);
    end
    assert (operand_ready_o == 1'b0) else begin
      errors++;
      $display("** Error: operand_ready_o = %h, expected %h", operand_ready_o, 1'b0);
    end
    assert (vinsn_done_o == '0) else begin
      errors++;
      $display("** Error: vinsn_done_o = %h, expected %h", vinsn_done_o, 8'h0);
    end
    assert (pe_req_ready_o == 1'b1) else begin
      errors++;
      $display("** Error: pe_req_ready_o = %h, expected %h", pe_req_ready_o, 1'b1);
    end

    // Each width, both directions, clean handshakes
    for (int op = 0; op < 2; op++) begin
      for (int k = 0; k < 4; k++) begin
        for (int n = 0; n < 4; n++) begin
          run_random(slide_pkg::slide_op_e'(op), slide_pkg::vew_e'(k));
          if (timed_out) return;
        end
      end
      end_reqs();
      wait_drain();
      if (timed_out) return;
    end

    // Random mix with grant stalls and operand gaps
    stall_en = 1'b1;
    for (int n = 0; n < 24; n++) begin
      r = draw_rand();
      run_random(slide_pkg::slide_op_e'(r[0]), slide_pkg::vew_e'(r[2:1]));
      if (timed_out) return;
    end
    end_reqs();
    wait_drain();
    stall_en = 1'b0;
    if (timed_out) return;

    // Withheld grants fill the instruction queue
    hold_gnt = 1'b1;
    for (int n = 0; n < InsnQueueDepth; n++) begin
      run_random(slide_pkg::slide_op_e'(n % 2), slide_pkg::EW16);
      if (timed_out) return;
    end
    end_reqs();
    repeat (20) @(negedge clk_i);
    checks = checks + 1;
    assert (!pe_req_ready_o) else begin
      errors++;
      $display("** Error: pe_req_ready_o = %h, expected %h", pe_req_ready_o, 1'b0);
    end
    hold_gnt = 1'b0;
    cnt      = 0;
    while (!pe_req_ready_o && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!pe_req_ready_o) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: pe_req_ready_o never recovered after grants resumed");
    end
    wait_drain();
  endtask

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    pe_req_valid_i  = 1'b0;
    pe_req_op_i     = slide_pkg::SLIDE_UP;
    pe_req_vsew_i   = slide_pkg::EW8;
    pe_req_vl_i     = '0;
    pe_req_stride_i = '0;
    pe_req_vd_i     = '0;
    pe_req_id_i     = '0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = '0;
    rng_q           = 32'hab1b_229a;
    stall_en        = 1'b0;
    hold_gnt        = 1'b0;
    timed_out       = 1'b0;
    next_id         = 0;
    errors          = 0;
    checks          = 0;
    dones           = 0;
    for (int l = 0; l < NrLanes; l++) held_q[l] = 1'b0;
    for (int a = 0; a < MemBytes; a++) begin
      mem_b[a] = poison(a);
      wr_b[a]  = 1'b0;
    end

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    run_all();

    $display("checks: %0d, errors: %0d, done pulses: %0d", checks, errors, dones);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/slide_unit.sv
`timescale 1ns/1ns

module slide_unit #(
  parameter int unsigned NrLanes        = 2,
  parameter int unsigned VLEN           = 512,
  parameter int unsigned InsnQueueDepth = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Sequencer requests
  input  logic                             pe_req_valid_i,
  input  slide_pkg::slide_op_e             pe_req_op_i,
  input  slide_pkg::vew_e                  pe_req_vsew_i,
  input  slide_pkg::vlen_t                 pe_req_vl_i,
  input  slide_pkg::vlen_t                 pe_req_stride_i,
  input  slide_pkg::vreg_t                 pe_req_vd_i,
  input  slide_pkg::vid_t                  pe_req_id_i,
  output logic                             pe_req_ready_o,
  // Source words streamed by the lanes
  input  slide_pkg::elen_t  [NrLanes-1:0]  operand_i,
  input  logic              [NrLanes-1:0]  operand_valid_i,
  output logic                             operand_ready_o,
  // Writes back to the lanes
  output logic              [NrLanes-1:0]  result_req_o,
  output slide_pkg::vaddr_t [NrLanes-1:0]  result_addr_o,
  output slide_pkg::elen_t  [NrLanes-1:0]  result_wdata_o,
  output slide_pkg::strb_t  [NrLanes-1:0]  result_be_o,
  input  logic              [NrLanes-1:0]  result_gnt_i,
  output logic [slide_pkg::NrVInsn-1:0]    vinsn_done_o
);

  slide_pkg::slide_insn_t req, issue_insn;
  logic                   issue_valid, issue_done, commit_last;

  slide_result_if #(.NrLanes(NrLanes)) res_if ();

  // Request fields gathered into one instruction word
  assign req = '{op:     pe_req_op_i,
                 vsew:   pe_req_vsew_i,
                 vl:     pe_req_vl_i,
                 stride: pe_req_stride_i,
                 vd:     pe_req_vd_i,
                 id:     pe_req_id_i};

  slide_insn_queue #(
    .InsnQueueDepth(InsnQueueDepth)
  ) i_insn_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req),
    .req_valid_i  (pe_req_valid_i),
    .req_ready_o  (pe_req_ready_o),
    .issue_insn_o (issue_insn),
    .issue_valid_o(issue_valid),
    .issue_done_i (issue_done),
    .commit_last_i(commit_last),
    .vinsn_done_o (vinsn_done_o)
  );

  slide_issue #(
    .NrLanes(NrLanes),
    .VLEN   (VLEN)
  ) i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (issue_insn),
    .insn_valid_i   (issue_valid),
    .insn_done_o    (issue_done),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .res            (res_if.master)
  );

  slide_result_queue #(
    .NrLanes(NrLanes)
  ) i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res          (res_if.slave),
    .req_o        (result_req_o),
    .addr_o       (result_addr_o),
    .wdata_o      (result_wdata_o),
    .be_o         (result_be_o),
    .gnt_i        (result_gnt_i),
    .commit_last_o(commit_last)
  );

endmodule

//--- design/slide_result_queue.sv
`timescale 1ns/1ns

module slide_result_queue #(
  parameter int unsigned NrLanes = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  slide_result_if.slave                    res,
  output logic              [NrLanes-1:0]  req_o,
  output slide_pkg::vaddr_t [NrLanes-1:0]  addr_o,
  output slide_pkg::elen_t  [NrLanes-1:0]  wdata_o,
  output slide_pkg::strb_t  [NrLanes-1:0]  be_o,
  input  logic              [NrLanes-1:0]  gnt_i,
  output logic                             commit_last_o
);

  localparam int unsigned Depth = 2;
  localparam int unsigned PntW  = $clog2(Depth);

  // Per entry, one payload and one request bit per lane
  slide_pkg::rq_payload_t [NrLanes-1:0] data_q  [Depth];
  logic                   [NrLanes-1:0] valid_q [Depth];
  logic                   [NrLanes-1:0] valid_d [Depth];
  logic                   [NrLanes-1:0] push_valid;

  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q, cnt_d;
  logic            retire;

  assign res.full = (cnt_q == (PntW+1)'(Depth));

  // Lanes with nothing to write raise no request
  always_comb begin : p_push_valid
    for (int unsigned l = 0; l < NrLanes; l++) begin
      push_valid[l] = |res.be[l];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane write requests
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    assign req_o[l]   = valid_q[rd_pnt_q][l];
    assign addr_o[l]  = data_q[rd_pnt_q][l].addr;
    assign wdata_o[l] = data_q[rd_pnt_q][l].wdata;
    assign be_o[l]    = data_q[rd_pnt_q][l].be;
  end

  always_comb begin : p_valid
    valid_d = valid_q;
    // A granted lane drops its request
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~gnt_i;
    // Head leaves as soon as every lane has been granted
    retire = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    if (res.push) begin
      valid_d[wr_pnt_q] = push_valid;
    end
  end

  assign commit_last_o = retire && data_q[rd_pnt_q][0].last;
  assign cnt_d         = cnt_q + (PntW+1)'(res.push) - (PntW+1)'(retire);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '{default: '0};
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_q + PntW'(res.push);
      rd_pnt_q <= rd_pnt_q + PntW'(retire);
      cnt_q    <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res.push) begin
      for (int unsigned l = 0; l < NrLanes; l++) begin
        data_q[wr_pnt_q][l] <= '{addr:  res.addr,
                                 wdata: res.wdata[l],
                                 be:    res.be[l],
                                 last:  res.last};
      end
    end
  end

  // Lanes only grant what they were asked for
  a_gnt_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_i & ~req_o) == '0)
    else $error("grant on a lane without a pending request");

endmodule

//--- design/slide_issue.sv
`timescale 1ns/1ns

module slide_issue #(
  parameter int unsigned NrLanes = 2,
  parameter int unsigned VLEN    = 512
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  slide_pkg::slide_insn_t          insn_i,
  input  logic                            insn_valid_i,
  output logic                            insn_done_o,
  input  slide_pkg::elen_t [NrLanes-1:0]  operand_i,
  input  logic             [NrLanes-1:0]  operand_valid_i,
  output logic                            operand_ready_o,
  slide_result_if.master                  res
);

  localparam int unsigned WordBytes   = NrLanes * slide_pkg::ElenBytes;
  localparam int unsigned WordsPerReg = VLEN / (8 * WordBytes);
  localparam int unsigned SelW        = $clog2(WordBytes);
  // One extra bit so a pointer can reach the word size
  localparam int unsigned PntW        = SelW + 1;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e                 state_q, state_d;
  logic [PntW-1:0]        in_pnt_q, in_pnt_d;
  logic [PntW-1:0]        out_pnt_q, out_pnt_d;
  slide_pkg::vaddr_t      vrf_pnt_q, vrf_pnt_d;
  // Bytes still to be written for this instruction
  slide_pkg::vlen_t       cnt_q, cnt_d;
  logic [8*WordBytes-1:0] acc_q, acc_d;
  logic [WordBytes-1:0]   be_q, be_d;

  logic [8*WordBytes-1:0] src_flat, rot;
  logic [SelW-1:0]        rot_amt;
  logic [PntW-1:0]        in_left, out_left, step;
  logic [WordBytes-1:0]   out_en;
  logic                   step_last;

  ////////////////////////////////////////////////////////////////////////////
  // Byte rotator
  ////////////////////////////////////////////////////////////////////////////

  // Lanes are flat, lane l holds bytes 8l to 8l+7
  assign src_flat = operand_i;
  // Output byte b takes input byte b + in_pnt - out_pnt
  assign rot_amt  = SelW'(in_pnt_q - out_pnt_q);

  always_comb begin : p_rotate
    logic [SelW-1:0] src_byte;
    for (int unsigned b = 0; b < WordBytes; b++) begin
      src_byte      = SelW'(b) + rot_amt;
      rot[8*b +: 8] = src_flat[8*src_byte +: 8];
    end
  end

  // Bytes moved this step, bounded by both words and the tail
  assign in_left  = PntW'(WordBytes) - in_pnt_q;
  assign out_left = PntW'(WordBytes) - out_pnt_q;

  always_comb begin : p_step
    step = (in_left < out_left) ? in_left : out_left;
    if (cnt_q < slide_pkg::vlen_t'(step)) begin
      step = PntW'(cnt_q);
    end
  end

  assign step_last = (cnt_q == slide_pkg::vlen_t'(step));

  always_comb begin : p_out_en
    for (int unsigned b = 0; b < WordBytes; b++) begin
      out_en[b] = (b >= out_pnt_q) && (b < out_pnt_q + step);
    end
  end

  // Result word as it stands after this step
  assign res.wdata = acc_d;
  assign res.be    = be_q | out_en;
  assign res.last  = step_last;
  assign res.addr  = slide_pkg::vaddr_t'(insn_i.vd * WordsPerReg) + vrf_pnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Slide FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    vrf_pnt_d       = vrf_pnt_q;
    cnt_d           = cnt_q;
    acc_d           = acc_q;
    be_d            = be_q;
    insn_done_o     = 1'b0;
    operand_ready_o = 1'b0;
    res.push        = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (insn_valid_i) begin
          state_d = RUN;
          be_d    = '0;
          if (insn_i.op == slide_pkg::SLIDE_UP) begin
            // Read from byte 0, write from the offset
            in_pnt_d  = '0;
            out_pnt_d = PntW'(insn_i.stride[SelW-1:0]);
            vrf_pnt_d = insn_i.stride >> SelW;
            cnt_d     = (insn_i.vl << insn_i.vsew) - insn_i.stride;
          end else begin
            // First word supplied is the one holding the offset
            in_pnt_d  = PntW'(insn_i.stride[SelW-1:0]);
            out_pnt_d = '0;
            vrf_pnt_d = '0;
            cnt_d     = insn_i.vl << insn_i.vsew;
          end
        end
      end

      RUN: begin
        // Whole operand word present and room downstream
        if (&operand_valid_i && !res.full) begin
          for (int unsigned b = 0; b < WordBytes; b++) begin
            if (out_en[b]) begin
              acc_d[8*b +: 8] = rot[8*b +: 8];
            end
          end
          be_d      = be_q | out_en;
          in_pnt_d  = in_pnt_q + step;
          out_pnt_d = out_pnt_q + step;
          cnt_d     = cnt_q - slide_pkg::vlen_t'(step);

          // Input word used up
          if (in_pnt_d == PntW'(WordBytes) || step_last) begin
            operand_ready_o = 1'b1;
            in_pnt_d        = '0;
          end

          // Output word complete
          if (out_pnt_d == PntW'(WordBytes) || step_last) begin
            res.push  = 1'b1;
            out_pnt_d = '0;
            vrf_pnt_d = vrf_pnt_q + 1'b1;
            be_d      = '0;
          end

          if (step_last) begin
            insn_done_o = 1'b1;
            state_d     = IDLE;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      vrf_pnt_q <= '0;
      cnt_q     <= '0;
      be_q      <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      vrf_pnt_q <= vrf_pnt_d;
      cnt_q     <= cnt_d;
      be_q      <= be_d;
    end
  end

  // Data bytes only matter where be is set
  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  // A running instruction always has bytes left, so the offset stays below vl
  a_run_has_bytes: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == RUN) |-> (cnt_q != '0))
    else $error("slide running with no bytes left to write");

endmodule

//--- design/slide_insn_queue.sv
`timescale 1ns/1ns

module slide_insn_queue #(
  parameter int unsigned InsnQueueDepth = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  slide_pkg::slide_insn_t        req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  output slide_pkg::slide_insn_t        issue_insn_o,
  output logic                          issue_valid_o,
  input  logic                          issue_done_i,
  input  logic                          commit_last_i,
  output logic [slide_pkg::NrVInsn-1:0] vinsn_done_o
);

  localparam int unsigned PntW = (InsnQueueDepth > 1) ? $clog2(InsnQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(InsnQueueDepth + 1);

  // Storage, written only on accept
  slide_pkg::slide_insn_t mem_q [InsnQueueDepth];
  slide_pkg::slide_insn_t req_conv;

  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [PntW-1:0] accept_pnt_d, issue_pnt_d, commit_pnt_d;
  logic [CntW-1:0] issue_cnt_q, commit_cnt_q;
  logic [CntW-1:0] issue_cnt_d, commit_cnt_d;
  logic            accept;
  logic [slide_pkg::NrVInsn-1:0] done_d;

  // Circular increment, depth need not be a power of two
  function automatic logic [PntW-1:0] bump(input logic [PntW-1:0] pnt);
    return (pnt == PntW'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Entries stay until their last result is committed
  assign req_ready_o = (commit_cnt_q != CntW'(InsnQueueDepth));
  assign accept      = req_valid_i && req_ready_o;

  // Slide amount turned into bytes on the way in
  always_comb begin : p_conv
    req_conv        = req_i;
    req_conv.stride = req_i.stride << req_i.vsew;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and count update
  ////////////////////////////////////////////////////////////////////////////

  assign accept_pnt_d = accept        ? bump(accept_pnt_q) : accept_pnt_q;
  assign issue_pnt_d  = issue_done_i  ? bump(issue_pnt_q)  : issue_pnt_q;
  assign commit_pnt_d = commit_last_i ? bump(commit_pnt_q) : commit_pnt_q;
  assign issue_cnt_d  = issue_cnt_q + CntW'(accept) - CntW'(issue_done_i);
  assign commit_cnt_d = commit_cnt_q + CntW'(accept) - CntW'(commit_last_i);

  // Done bit of the instruction whose last word retired
  always_comb begin : p_done
    done_d = '0;
    if (commit_last_i) begin
      done_d[mem_q[commit_pnt_q].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      issue_valid_o <= 1'b0;
      vinsn_done_o  <= '0;
    end else begin
      accept_pnt_q  <= accept_pnt_d;
      issue_pnt_q   <= issue_pnt_d;
      commit_pnt_q  <= commit_pnt_d;
      issue_cnt_q   <= issue_cnt_d;
      commit_cnt_q  <= commit_cnt_d;
      issue_valid_o <= (issue_cnt_d != '0);
      vinsn_done_o  <= done_d;
    end
  end

  // Head is registered, new entries bypass the array
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= req_conv;
    end
    if (accept && (accept_pnt_q == issue_pnt_d)) begin
      issue_insn_o <= req_conv;
    end else begin
      issue_insn_o <= mem_q[issue_pnt_d];
    end
  end

  // Issue stage finishes only what was handed to it
  a_done_has_insn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_done_i |-> (issue_cnt_q != '0))
    else $error("issue_done with no instruction pending issue");

endmodule

//--- design/slide_result_if.sv
`timescale 1ns/1ns

// Result words from the issue stage towards the result queue
interface slide_result_if #(
  parameter int unsigned NrLanes = 2
);

  // Single-cycle write strobe, only legal while full is low
  logic                                push;
  logic                                full;
  // Register file word address, shared by all lanes
  slide_pkg::vaddr_t                   addr;
  slide_pkg::elen_t  [NrLanes-1:0]     wdata;
  slide_pkg::strb_t  [NrLanes-1:0]     be;
  // Final word of the instruction
  logic                                last;

  modport master (
    output push, addr, wdata, be, last,
    input  full
  );

  modport slave (
    input  push, addr, wdata, be, last,
    output full
  );

endinterface

//--- design/slide_pkg.sv
package slide_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////

  // One lane word is a full 64-bit element
  localparam int unsigned ElenBits  = 64;
  localparam int unsigned ElenBytes = ElenBits / 8;

  // Instruction ids in flight across the vector machine
  localparam int unsigned NrVInsn = 8;

  typedef logic [ElenBits-1:0]         elen_t;
  typedef logic [ElenBytes-1:0]        strb_t;
  typedef logic [$clog2(NrVInsn)-1:0]  vid_t;
  typedef logic [15:0]                 vaddr_t;
  // Vector length and slide amount, both 16 bits
  typedef logic [15:0]                 vlen_t;
  // Architectural vector register index
  typedef logic [4:0]                  vreg_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction and result formats
  ////////////////////////////////////////////////////////////////////////////

  // Element width, byte count is 1 << code
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  // Stride arrives in elements and is held in bytes once queued
  typedef struct packed {
    slide_op_e op;
    vew_e      vsew;
    vlen_t     vl;
    vlen_t     stride;
    vreg_t     vd;
    vid_t      id;
  } slide_insn_t;

  // Per-lane entry of the result queue
  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
    logic   last;
  } rq_payload_t;

endpackage
